//--- tb.f
rtl/mips_pkg.sv
rtl/mips_decoder.sv
rtl/mips_reg_file.sv
rtl/mips_alu.sv
rtl/mips_mem_align.sv
rtl/mips_control.sv
rtl/mips_cpu_bus.sv
dv/mips_assert.sv
dv/mips_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := mips_tb
FILELIST  := tb.f
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- dv/mips_tb.sv
`timescale 1ns/10ps

module mips_tb;

    localparam time clk_period = 4ns;
    localparam int num_tests = 5;
    localparam int cycles_per_test = 2000;
    localparam logic [31:0] prog_base = 32'hBFC0_0000;
    localparam logic [31:0] data_base = 32'h0000_1000;

    // Primary opcodes and R-type function codes
    localparam logic [5:0] op_j = 6'h02, op_beq = 6'h04, op_bne = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09, op_sltiu = 6'h0B, op_andi = 6'h0C;
    localparam logic [5:0] op_ori = 6'h0D, op_xori = 6'h0E, op_lui = 6'h0F;
    localparam logic [5:0] op_lb = 6'h20, op_lw = 6'h23, op_lbu = 6'h24, op_sw = 6'h2B;
    localparam logic [5:0] fn_sll = 6'h00, fn_srl = 6'h02, fn_sra = 6'h03, fn_jr = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21, fn_subu = 6'h23, fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25, fn_xor = 6'h26, fn_slt = 6'h2A, fn_sltu = 6'h2B;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        waitrequest = 1'b0;
    logic [31:0] readdata = 32'h0;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] prog [256];
    logic [31:0] data_mem [256];
    int          prog_len;
    int          forced_wait = 0;
    int          wait_left;
    bit          in_xfer = 1'b0;
    // Byte enables of the data transfers a program should make, in order
    logic [3:0]  expected_be [$];

    mips_cpu_bus i_dut (
        .clk, .reset, .active, .register_v0,
        .address, .write, .read, .waitrequest,
        .writedata, .byteenable, .readdata
    );

    initial begin
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        #(num_tests * cycles_per_test * clk_period);
        $display("timeout: the program did not halt in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // Unmapped addresses read back a pattern of the full address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h5A5A, ~addr[31:16]} ^ addr;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (addr[31:10] == prog_base[31:10]) begin
            return prog[addr[9:2]];
        end else if (addr[31:10] == data_base[31:10]) begin
            return data_mem[addr[9:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic mem_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
        if (addr[31:10] == data_base[31:10]) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    data_mem[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end
    endtask

    // Avalon slave, waitrequest is set up one falling edge ahead
    always @(negedge clk) begin
        if (reset) begin
            in_xfer = 1'b0;
            waitrequest <= 1'b1;
        end else begin
            if (!in_xfer && (read || write)) begin
                in_xfer = 1'b1;
                wait_left = (forced_wait != 0) ? forced_wait : int'($urandom % 4);
            end
            if (in_xfer) begin
                if (wait_left > 0) begin
                    waitrequest <= 1'b1;
                    wait_left--;
                end else begin
                    waitrequest <= 1'b0;
                    if (address[31:10] == data_base[31:10]) begin
                        check_byteenable(byteenable);
                    end
                    if (read) begin
                        readdata <= mem_read(address);
                    end else begin
                        mem_write(address, writedata, byteenable);
                    end
                    in_xfer = 1'b0;
                end
            end else begin
                waitrequest <= 1'b0;
            end
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("error at %0t: %s", $time, reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_byteenable(input logic [3:0] be);
        if (expected_be.size() == 0) begin
            stop_with_failure("the program made a data transfer that was not expected");
        end else begin
            check("byteenable", {28'h0, be}, {28'h0, expected_be.pop_front()});
        end
    endtask

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sh,
                                             input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic clear_memory();
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'h0;
            data_mem[i] = fill_word(data_base + 32'(4 * i));
        end
    endtask

    // Every program returns through JR $0 with a NOP in its delay slot
    task automatic run_program();
        emit(encode_r(5'd0, 5'd0, 5'd0, 5'd0, fn_jr));
        emit(32'h0);
        reset <= 1'b1;
        repeat (8) @(negedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (active !== 1'b0) begin
            @(negedge clk);
        end
        if (expected_be.size() != 0) begin
            stop_with_failure("the program halted before all its data transfers");
        end
    endtask

    task automatic alu_test();
        logic [31:0] r3, r4, r5, r6, r7, r8, r9, r10, r11, r12, r13, v0;
        clear_memory();
        emit(encode_i(op_addiu, 5'd0, 5'd3, 16'hFFFB));
        emit(encode_i(op_sltiu, 5'd3, 5'd4, 16'hFFFF));
        emit(encode_r(5'd0, 5'd3, 5'd5, 5'd1, fn_sra));
        emit(encode_i(op_lui, 5'd0, 5'd6, 16'h1234));
        emit(encode_i(op_ori, 5'd6, 5'd6, 16'h8765));
        emit(encode_i(op_andi, 5'd3, 5'd7, 16'hFF00));
        emit(encode_i(op_xori, 5'd7, 5'd8, 16'h0F0F));
        emit(encode_r(5'd6, 5'd3, 5'd9, 5'd0, fn_subu));
        emit(encode_r(5'd3, 5'd4, 5'd10, 5'd0, fn_slt));
        emit(encode_r(5'd3, 5'd4, 5'd11, 5'd0, fn_sltu));
        emit(encode_r(5'd0, 5'd3, 5'd12, 5'd28, fn_srl));
        emit(encode_r(5'd0, 5'd12, 5'd13, 5'd4, fn_sll));
        emit(encode_r(5'd4, 5'd5, 5'd2, 5'd0, fn_addu));
        emit(encode_r(5'd2, 5'd9, 5'd2, 5'd0, fn_addu));
        emit(encode_r(5'd2, 5'd8, 5'd2, 5'd0, fn_xor));
        emit(encode_r(5'd2, 5'd13, 5'd2, 5'd0, fn_or));
        emit(encode_r(5'd2, 5'd10, 5'd2, 5'd0, fn_addu));
        emit(encode_r(5'd2, 5'd11, 5'd2, 5'd0, fn_addu));
        emit(encode_r(5'd2, 5'd3, 5'd2, 5'd0, fn_and));
        run_program();
        // Expected values from the MIPS rules
        r3 = sext16(16'hFFFB);
        r4 = (r3 < sext16(16'hFFFF)) ? 32'd1 : 32'd0;
        r5 = $signed(r3) >>> 1;
        r6 = {16'h1234, 16'h0000} | {16'h0000, 16'h8765};
        r7 = r3 & {16'h0000, 16'hFF00};
        r8 = r7 ^ {16'h0000, 16'h0F0F};
        r9 = r6 - r3;
        r10 = ($signed(r3) < $signed(r4)) ? 32'd1 : 32'd0;
        r11 = (r3 < r4) ? 32'd1 : 32'd0;
        r12 = r3 >> 28;
        r13 = r12 << 4;
        v0 = ((((((r4 + r5) + r9) ^ r8) | r13) + r10) + r11) & r3;
        check("register_v0", register_v0, v0);
        repeat (50) begin
            @(negedge clk);
            check("read and write while halted", {30'b0, read, write}, 32'h0);
        end
    endtask

    task automatic word_memory_test();
        clear_memory();
        emit(encode_i(op_addiu, 5'd0, 5'd8, 16'h1000));
        emit(encode_i(op_lui, 5'd0, 5'd9, 16'hCAFE));
        emit(encode_i(op_ori, 5'd9, 5'd9, 16'hF00D));
        emit(encode_i(op_sw, 5'd8, 5'd9, 16'h0000));
        emit(encode_i(op_lw, 5'd8, 5'd2, 16'h0000));
        expected_be.push_back(4'b1111);
        expected_be.push_back(4'b1111);
        run_program();
        check("register_v0", register_v0, 32'hCAFE_F00D);
        check("memory word 0x1000", data_mem[0], 32'hCAFE_F00D);
    endtask

    task automatic byte_load_test();
        logic [31:0] word;
        logic [31:0] v0;
        logic [7:0]  b;
        clear_memory();
        word = 32'h8F7F_1A90;
        data_mem[4] = word;
        v0 = 32'h0;
        emit(encode_i(op_addiu, 5'd0, 5'd8, 16'h1010));
        for (int k = 0; k < 4; k++) begin
            emit(encode_i(op_lb, 5'd8, 5'd3, 16'(k)));
            emit(encode_r(5'd0, 5'd2, 5'd2, 5'd3, fn_sll));
            emit(encode_r(5'd2, 5'd3, 5'd2, 5'd0, fn_addu));
            emit(encode_i(op_lbu, 5'd8, 5'd3, 16'(k)));
            emit(encode_r(5'd0, 5'd2, 5'd2, 5'd3, fn_sll));
            emit(encode_r(5'd2, 5'd3, 5'd2, 5'd0, fn_addu));
            // One byte lane enabled, picked by the offset
            expected_be.push_back(4'b0001 << k);
            expected_be.push_back(4'b0001 << k);
            b = word[8*k +: 8];
            v0 = (v0 << 3) + {{24{b[7]}}, b};
            v0 = (v0 << 3) + {24'h0, b};
        end
        run_program();
        check("register_v0", register_v0, v0);
    endtask

    task automatic branch_test();
        logic [31:0] target;
        clear_memory();
        target = prog_base + 32'd44;
        emit(encode_i(op_addiu, 5'd0, 5'd3, 16'd1));
        emit(encode_i(op_beq, 5'd0, 5'd0, 16'd2));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd1));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd2));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd4));
        emit(encode_i(op_bne, 5'd0, 5'd0, 16'd2));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd8));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd16));
        emit({op_j, target[27:2]});
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd32));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd64));
        emit(encode_i(op_addiu, 5'd2, 5'd2, 16'd128));
        run_program();
        // Skipped: 2 after BEQ and 64 after J
        check("register_v0", register_v0, 32'd1 + 32'd4 + 32'd8 + 32'd16 + 32'd32 + 32'd128);
    endtask

    initial begin
        void'($urandom(32'h6292));
        alu_test();
        word_memory_test();
        byte_load_test();
        branch_test();
        forced_wait = 5;
        alu_test();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- dv/mips_assert.sv
`timescale 1ns/10ps

module mips_assert (
    input logic        clk,
    input logic        reset,
    input logic        active,
    input logic [31:0] address,
    input logic        read,
    input logic        write,
    input logic [31:0] writedata,
    input logic        waitrequest
);

    a_no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write high together");

    // A stalled transfer must hold its request
    a_stable: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
        else $error("bus outputs changed while waitrequest was high");

    a_halted_idle: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("transfer while halted");

    a_aligned: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> address[1:0] == 2'b00)
        else $error("unaligned bus address");

endmodule

bind mips_cpu_bus mips_assert i_assert (
    .clk, .reset, .active, .address, .read, .write, .writedata, .waitrequest
);

//--- rtl/mips_cpu_bus.sv
`timescale 1ns/10ps

module mips_cpu_bus #(
    parameter logic [mips_pkg::data_width-1:0] reset_vector = mips_pkg::default_reset_vector
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            active,
    output logic [mips_pkg::data_width-1:0] register_v0,

    // Avalon master, shared by fetch and data accesses
    output logic [mips_pkg::data_width-1:0] address,
    output logic                            write,
    output logic                            read,
    input  logic                            waitrequest,
    output logic [mips_pkg::data_width-1:0] writedata,
    output logic [3:0]                      byteenable,
    input  logic [mips_pkg::data_width-1:0] readdata
);
    import mips_pkg::*;

    logic [data_width-1:0]     instr;
    state_t                    state;
    logic                      reg_we;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] dest;
    logic [4:0]                shamt;
    logic [data_width-1:0]     imm_ext;
    logic                      use_imm;
    alu_op_t                   alu_op;
    mem_op_t                   mem_op;
    logic                      is_branch;
    logic                      is_bne;
    logic                      is_jump;
    logic                      is_jr;
    logic                      rd_write;
    logic [25:0]               jump_index;
    logic [data_width-1:0]     rs_value;
    logic [data_width-1:0]     rt_value;
    logic [data_width-1:0]     result;
    logic                      equal;
    logic [data_width-1:0]     data_address;
    logic [3:0]                data_byteenable;
    logic [data_width-1:0]     load_value;
    logic [data_width-1:0]     wb_value;

    // Loaded data in MEM, ALU result otherwise
    assign wb_value = (state == MEM && mem_op != MEM_NONE) ? load_value : result;

    mips_control #(
        .reset_vector (reset_vector)
    ) i_control (
        .clk, .reset, .waitrequest, .readdata,
        .mem_op, .is_branch, .is_bne, .is_jump, .is_jr,
        .jump_index, .imm_ext, .rs_value, .taken_cond (equal),
        .rd_write, .data_address, .data_byteenable,
        .instr, .state, .reg_we,
        .address, .read, .write, .byteenable, .active
    );

    mips_decoder i_decoder (
        .instr, .rs, .rt, .dest, .shamt, .imm_ext, .use_imm, .alu_op, .mem_op,
        .is_branch, .is_bne, .is_jump, .is_jr, .rd_write, .jump_index
    );

    mips_reg_file i_reg_file (
        .clk, .reset, .rs, .rt, .dest, .we (reg_we), .wdata (wb_value),
        .rs_value, .rt_value, .register_v0
    );

    mips_alu i_alu (
        .alu_op, .a (rs_value), .b (rt_value), .use_imm, .imm_ext, .shamt,
        .result, .equal
    );

    mips_mem_align i_mem_align (
        .mem_op, .effective_address (result), .store_value (rt_value), .readdata,
        .data_address, .data_byteenable, .writedata, .load_value
    );

endmodule

//--- rtl/mips_control.sv
`timescale 1ns/10ps

module mips_control #(
    parameter logic [mips_pkg::data_width-1:0] reset_vector = mips_pkg::default_reset_vector
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            waitrequest,
    input  logic [mips_pkg::data_width-1:0] readdata,
    input  mips_pkg::mem_op_t               mem_op,
    input  logic                            is_branch,
    input  logic                            is_bne,
    input  logic                            is_jump,
    input  logic                            is_jr,
    input  logic [25:0]                     jump_index,
    input  logic [mips_pkg::data_width-1:0] imm_ext,
    input  logic [mips_pkg::data_width-1:0] rs_value,
    input  logic                            taken_cond,
    input  logic                            rd_write,
    input  logic [mips_pkg::data_width-1:0] data_address,
    input  logic [3:0]                      data_byteenable,
    output logic [mips_pkg::data_width-1:0] instr,
    output mips_pkg::state_t                state,
    output logic                            reg_we,
    output logic [mips_pkg::data_width-1:0] address,
    output logic                            read,
    output logic                            write,
    output logic [3:0]                      byteenable,
    output logic                            active
);
    import mips_pkg::*;

    logic [data_width-1:0] pc;
    logic [data_width-1:0] pc_plus4;
    logic [data_width-1:0] next_pc;
    logic [data_width-1:0] branch_target;
    logic [data_width-1:0] jump_target;
    logic [data_width-1:0] taken_target;
    logic [data_width-1:0] target_q;
    logic                  delay;
    logic                  taken;
    logic                  is_load;
    logic                  bus_done;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[data_width-3:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

    always_comb begin
        if (is_jr) begin
            taken_target = rs_value;
        end else if (is_jump) begin
            taken_target = jump_target;
        end else begin
            taken_target = branch_target;
        end
    end

    assign taken   = is_jr | is_jump | (is_branch & (taken_cond ^ is_bne));
    // Delay slot runs first, then the recorded target takes over
    assign next_pc = delay ? target_q : pc_plus4;

    assign is_load  = (mem_op == MEM_LW) || (mem_op == MEM_LB) || (mem_op == MEM_LBU);
    assign bus_done = !waitrequest;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= reset_vector;
            delay <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (bus_done) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    pc    <= next_pc;
                    delay <= taken;
                    if (mem_op != MEM_NONE) begin
                        state <= MEM;
                    end else if (next_pc == '0) begin
                        state <= HALTED;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM: begin
                    // pc already moved on in EXEC
                    if (bus_done) begin
                        state <= (pc == '0) ? HALTED : FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    // Instruction register and pending target
    always_ff @(posedge clk) begin
        if (state == FETCH && bus_done) begin
            instr <= readdata;
        end
        if (state == EXEC && taken) begin
            target_q <= taken_target;
        end
    end

    assign active = (state != HALTED);

    always_comb begin
        address    = pc;
        read       = 1'b0;
        write      = 1'b0;
        byteenable = 4'b0000;
        case (state)
            FETCH: begin
                read       = 1'b1;
                byteenable = 4'b1111;
            end
            MEM: begin
                address    = data_address;
                read       = is_load;
                write      = (mem_op == MEM_SW);
                byteenable = data_byteenable;
            end
            default: ;
        endcase
    end

    // Loads write back only once the read data has arrived
    assign reg_we = (state == EXEC && rd_write && mem_op == MEM_NONE)
                 || (state == MEM && rd_write && bus_done);

endmodule

//--- rtl/mips_mem_align.sv
`timescale 1ns/10ps

module mips_mem_align (
    input  mips_pkg::mem_op_t               mem_op,
    input  logic [mips_pkg::data_width-1:0] effective_address,
    input  logic [mips_pkg::data_width-1:0] store_value,
    input  logic [mips_pkg::data_width-1:0] readdata,
    output logic [mips_pkg::data_width-1:0] data_address,
    output logic [3:0]                      data_byteenable,
    output logic [mips_pkg::data_width-1:0] writedata,
    output logic [mips_pkg::data_width-1:0] load_value
);
    import mips_pkg::*;

    logic [1:0] lane;
    logic [7:0] load_byte;

    assign lane = effective_address[1:0];

    // Bus is word addressed, lane picks the byte
    assign data_address = {effective_address[data_width-1:2], 2'b00};

    // Only whole words are stored
    assign writedata = store_value;

    always_comb begin
        case (mem_op)
            MEM_LB, MEM_LBU: data_byteenable = 4'b0001 << lane;
            MEM_LW, MEM_SW:  data_byteenable = 4'b1111;
            default:         data_byteenable = 4'b0000;
        endcase
    end

    // Little-endian lane order, byte 0 in bits 7..0
    always_comb begin
        case (lane)
            2'd0:    load_byte = readdata[7:0];
            2'd1:    load_byte = readdata[15:8];
            2'd2:    load_byte = readdata[23:16];
            default: load_byte = readdata[31:24];
        endcase
    end

    always_comb begin
        case (mem_op)
            MEM_LB:  load_value = {{(data_width-8){load_byte[7]}}, load_byte};
            MEM_LBU: load_value = {{(data_width-8){1'b0}}, load_byte};
            default: load_value = readdata;
        endcase
    end

endmodule

//--- rtl/mips_alu.sv
`timescale 1ns/10ps

module mips_alu (
    input  mips_pkg::alu_op_t               alu_op,
    input  logic [mips_pkg::data_width-1:0] a,
    input  logic [mips_pkg::data_width-1:0] b,
    input  logic                            use_imm,
    input  logic [mips_pkg::data_width-1:0] imm_ext,
    input  logic [4:0]                      shamt,
    output logic [mips_pkg::data_width-1:0] result,
    output logic                            equal
);
    import mips_pkg::*;

    logic [data_width-1:0] op_b;
    logic                  lt_signed;
    logic                  lt_unsigned;

    // Second operand is rt or the extended immediate
    assign op_b = use_imm ? imm_ext : b;

    assign lt_signed   = $signed(a) < $signed(op_b);
    assign lt_unsigned = a < op_b;

    // Branch condition, BEQ versus BNE is resolved in control
    assign equal = (a == op_b);

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + op_b;
            ALU_SUB:  result = a - op_b;
            ALU_AND:  result = a & op_b;
            ALU_OR:   result = a | op_b;
            ALU_XOR:  result = a ^ op_b;
            ALU_SLT:  result = {{(data_width-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(data_width-1){1'b0}}, lt_unsigned};
            // Shifts act on rt by the shamt field
            ALU_SLL:  result = op_b << shamt;
            ALU_SRL:  result = op_b >> shamt;
            ALU_SRA:  result = $signed(op_b) >>> shamt;
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            default:  result = a + op_b;
        endcase
    end

endmodule

//--- rtl/mips_reg_file.sv
`timescale 1ns/10ps

module mips_reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mips_pkg::reg_addr_width-1:0] rs,
    input  logic [mips_pkg::reg_addr_width-1:0] rt,
    input  logic [mips_pkg::reg_addr_width-1:0] dest,
    input  logic                                we,
    input  logic [mips_pkg::data_width-1:0]     wdata,
    output logic [mips_pkg::data_width-1:0]     rs_value,
    output logic [mips_pkg::data_width-1:0]     rt_value,
    output logic [mips_pkg::data_width-1:0]     register_v0
);
    import mips_pkg::*;

    localparam int num_regs = 2 ** reg_addr_width;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && dest != '0) begin
            // $zero stays at its reset value
            regs[dest] <= wdata;
        end
    end

    assign rs_value = regs[rs];
    assign rt_value = regs[rt];

    // v0 holds the program result
    assign register_v0 = regs[2];

endmodule

//--- rtl/mips_decoder.sv
`timescale 1ns/10ps

module mips_decoder (
    input  logic [mips_pkg::data_width-1:0]     instr,
    output logic [mips_pkg::reg_addr_width-1:0] rs,
    output logic [mips_pkg::reg_addr_width-1:0] rt,
    output logic [mips_pkg::reg_addr_width-1:0] dest,
    output logic [4:0]                          shamt,
    output logic [mips_pkg::data_width-1:0]     imm_ext,
    output logic                                use_imm,
    output mips_pkg::alu_op_t                   alu_op,
    output mips_pkg::mem_op_t                   mem_op,
    output logic                                is_branch,
    output logic                                is_bne,
    output logic                                is_jump,
    output logic                                is_jr,
    output logic                                rd_write,
    output logic [25:0]                         jump_index
);
    import mips_pkg::*;

    opcode_t     opcode;
    function_t   funct;
    logic [15:0] imm;
    logic        sign_ext;

    assign opcode     = opcode_t'(instr[31:26]);
    assign funct      = function_t'(instr[5:0]);
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign shamt      = instr[10:6];
    assign imm        = instr[15:0];
    assign jump_index = instr[25:0];

    // Logic immediates and LUI take zero extension, everything else sign
    assign imm_ext = sign_ext ? {{(data_width-16){imm[15]}}, imm}
                              : {{(data_width-16){1'b0}}, imm};

    always_comb begin
        dest      = instr[20:16];
        use_imm   = 1'b1;
        sign_ext  = 1'b1;
        alu_op    = ALU_ADD;
        mem_op    = MEM_NONE;
        is_branch = 1'b0;
        is_bne    = 1'b0;
        is_jump   = 1'b0;
        is_jr     = 1'b0;
        rd_write  = 1'b0;
        case (opcode)
            OPCODE_R: begin
                dest     = instr[15:11];
                use_imm  = 1'b0;
                rd_write = 1'b1;
                case (funct)
                    FUNCTION_ADDU: alu_op = ALU_ADD;
                    FUNCTION_SUBU: alu_op = ALU_SUB;
                    FUNCTION_AND:  alu_op = ALU_AND;
                    FUNCTION_OR:   alu_op = ALU_OR;
                    FUNCTION_XOR:  alu_op = ALU_XOR;
                    FUNCTION_SLT:  alu_op = ALU_SLT;
                    FUNCTION_SLTU: alu_op = ALU_SLTU;
                    FUNCTION_SLL:  alu_op = ALU_SLL;
                    FUNCTION_SRL:  alu_op = ALU_SRL;
                    FUNCTION_SRA:  alu_op = ALU_SRA;
                    FUNCTION_JR: begin
                        is_jr    = 1'b1;
                        rd_write = 1'b0;
                    end
                    default: rd_write = 1'b0;
                endcase
            end
            OPCODE_ADDIU: rd_write = 1'b1;
            OPCODE_SLTIU: begin
                alu_op   = ALU_SLTU;
                rd_write = 1'b1;
            end
            OPCODE_ANDI, OPCODE_ORI, OPCODE_XORI, OPCODE_LUI: begin
                sign_ext = 1'b0;
                rd_write = 1'b1;
                alu_op   = (opcode == OPCODE_ANDI) ? ALU_AND :
                           (opcode == OPCODE_ORI)  ? ALU_OR  :
                           (opcode == OPCODE_XORI) ? ALU_XOR : ALU_LUI;
            end
            OPCODE_BEQ, OPCODE_BNE: begin
                // Compare rs against rt, the offset only feeds the target
                use_imm   = 1'b0;
                is_branch = 1'b1;
                is_bne    = (opcode == OPCODE_BNE);
            end
            OPCODE_J: is_jump = 1'b1;
            OPCODE_LW: begin
                mem_op   = MEM_LW;
                rd_write = 1'b1;
            end
            OPCODE_LB: begin
                mem_op   = MEM_LB;
                rd_write = 1'b1;
            end
            OPCODE_LBU: begin
                mem_op   = MEM_LBU;
                rd_write = 1'b1;
            end
            OPCODE_SW: mem_op = MEM_SW;
            default: ;
        endcase
    end

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

    // Datapath widths
    localparam int data_width = 32;
    localparam int reg_addr_width = 5;

    // First fetch address after reset
    localparam logic [31:0] default_reset_vector = 32'hBFC0_0000;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OPCODE_R     = 6'b000000,
        OPCODE_J     = 6'b000010,
        OPCODE_BEQ   = 6'b000100,
        OPCODE_BNE   = 6'b000101,
        OPCODE_ADDIU = 6'b001001,
        OPCODE_SLTIU = 6'b001011,
        OPCODE_ANDI  = 6'b001100,
        OPCODE_ORI   = 6'b001101,
        OPCODE_XORI  = 6'b001110,
        OPCODE_LUI   = 6'b001111,
        OPCODE_LB    = 6'b100000,
        OPCODE_LW    = 6'b100011,
        OPCODE_LBU   = 6'b100100,
        OPCODE_SW    = 6'b101011
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FUNCTION_SLL  = 6'b000000,
        FUNCTION_SRL  = 6'b000010,
        FUNCTION_SRA  = 6'b000011,
        FUNCTION_JR   = 6'b001000,
        FUNCTION_ADDU = 6'b100001,
        FUNCTION_SUBU = 6'b100011,
        FUNCTION_AND  = 6'b100100,
        FUNCTION_OR   = 6'b100101,
        FUNCTION_XOR  = 6'b100110,
        FUNCTION_SLT  = 6'b101010,
        FUNCTION_SLTU = 6'b101011
    } function_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // Five kinds of memory access need three bits
    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW
    } mem_op_t;

    typedef enum logic [1:0] {
        FETCH, EXEC, MEM, HALTED
    } state_t;

endpackage
